/* sim.f */
+incdir+src
src/cam_csr_pkg.sv
src/cam_axil_port.sv
src/cam_config_regs.sv
src/cam_event_unit.sv
src/cam_csr_top.sv
verif/tb_cam_csr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CSR block testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sim.f --top-module tb_cam_csr -o tb_cam_csr

./obj_dir/tb_cam_csr > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_cam_csr.sv */
`timescale 1ns/10ps
`include "cam_csr_cfg.svh"

module tb_cam_csr
    import cam_csr_pkg::*;
();

localparam int TIMEOUT = 50;

logic                   aclk;
logic                   aresetn;
csr_addr_t              s_axi_awaddr;
logic                   s_axi_awvalid;
logic                   s_axi_awready;
csr_data_t              s_axi_wdata;
csr_strb_t              s_axi_wstrb;
logic                   s_axi_wvalid;
logic                   s_axi_wready;
resp_t                  s_axi_bresp;
logic                   s_axi_bvalid;
logic                   s_axi_bready;
csr_addr_t              s_axi_araddr;
logic                   s_axi_arvalid;
logic                   s_axi_arready;
csr_data_t              s_axi_rdata;
resp_t                  s_axi_rresp;
logic                   s_axi_rvalid;
logic                   s_axi_rready;
logic                   soft_reset;
logic                   serdes_enable;
logic                   subsample;
logic                   exposure_enable;
logic                   trigger_enable;
logic                   vcap_enable;
logic                   tag_enable;
logic                   spi_start;
logic [`SPI_ADDR_W-1:0] spi_addr;
spi_op_e                spi_op;
logic [`SPI_DATA_W-1:0] spi_wdata;
logic [`SPI_DATA_W-1:0] spi_rdata;
logic                   spi_ready;
csr_data_t              frame_period;
csr_data_t              exposure_0;
csr_data_t              exposure_1;
csr_data_t              exposure_2;
csr_data_t              strobe_period;
csr_data_t              strobe_width;
logic                   serdes_locked;
logic                   vcap_in_done;
logic                   vcap_out_done;
logic                   tag_in_done;
logic                   vcap_current;
logic                   tag_current;
logic                   irq_request;

int        errors;
int        timeouts;
int        seed;
csr_data_t model [0:`CSR_WORD_N-1];
csr_data_t last_rdata;
resp_t     last_rresp;
logic      start_first;
int        start_hits;
int        wr_list [8] = '{0, 2, 4, 5, 6, 7, 8, 9};
// CTRL bit of each interrupt source
int        irq_bit [5] = '{4, 7, 20, 22, 28};

cam_csr_top uut (.*);

initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
end

task automatic compare(input string what, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite master
task automatic axi_write(input int idx, input csr_data_t data, input csr_strb_t strb,
                         input int stall);
    int t;
    int i;
    t = 0;
    @(negedge aclk);
    s_axi_awaddr  = {idx[5:0], 2'b00};
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    #1;
    while (!(s_axi_awready && s_axi_wready) && t < TIMEOUT) begin
        @(negedge aclk);
        #1;
        t++;
    end
    if (!(s_axi_awready && s_axi_wready)) begin
        $display("timeout waiting for the write handshake at %0t", $time);
        timeouts++;
    end
    // handshake on the coming rising edge
    @(negedge aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    start_first = spi_start;
    start_hits  = spi_start ? 1 : 0;
    t = 0;
    while (!s_axi_bvalid && t < TIMEOUT) begin
        @(negedge aclk);
        if (spi_start) start_hits++;
        t++;
    end
    if (!s_axi_bvalid) begin
        $display("timeout waiting for bvalid at %0t", $time);
        timeouts++;
    end
    compare("bresp", 32'(s_axi_bresp), 32'(OKAY));
    for (i = 0; i < stall; i++) begin
        // second write offered while the response waits
        s_axi_awaddr  = 8'hfc;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        #1;
        if (s_axi_awready || s_axi_wready) begin
            $display("** Error at %0t: write accepted while bvalid pending", $time);
            errors++;
        end
        @(negedge aclk);
        if (spi_start) start_hits++;
        compare("bvalid during stall", 32'(s_axi_bvalid), 32'd1);
    end
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    @(negedge aclk);
    if (spi_start) start_hits++;
    s_axi_bready = 1'b0;
    compare("bvalid after bready", 32'(s_axi_bvalid), 32'd0);
endtask

task automatic axi_read(input int idx, input int stall);
    int t;
    int i;
    t = 0;
    @(negedge aclk);
    s_axi_araddr  = {idx[5:0], 2'b00};
    s_axi_arvalid = 1'b1;
    #1;
    while (!s_axi_arready && t < TIMEOUT) begin
        @(negedge aclk);
        #1;
        t++;
    end
    if (!s_axi_arready) begin
        $display("timeout waiting for arready at %0t", $time);
        timeouts++;
    end
    @(negedge aclk);
    s_axi_arvalid = 1'b0;
    t = 0;
    while (!s_axi_rvalid && t < TIMEOUT) begin
        @(negedge aclk);
        t++;
    end
    if (!s_axi_rvalid) begin
        $display("timeout waiting for rvalid at %0t", $time);
        timeouts++;
    end
    last_rdata = s_axi_rdata;
    last_rresp = s_axi_rresp;
    for (i = 0; i < stall; i++) begin
        s_axi_araddr  = 8'h00;
        s_axi_arvalid = 1'b1;
        #1;
        if (s_axi_arready) begin
            $display("** Error at %0t: read accepted while rvalid pending", $time);
            errors++;
        end
        @(negedge aclk);
        compare("rvalid during stall", 32'(s_axi_rvalid), 32'd1);
        compare("rdata during stall", s_axi_rdata, last_rdata);
    end
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    @(negedge aclk);
    s_axi_rready = 1'b0;
    compare("rvalid after rready", 32'(s_axi_rvalid), 32'd0);
endtask

////////////////////////////////////////////////////////////////////////////
// register model
task automatic model_write(input int idx, input csr_data_t data, input csr_strb_t strb);
    int b;
    if (idx == 0 || idx == 2 || (idx >= 4 && idx < `CSR_WORD_N)) begin
        for (b = 0; b < 4; b++) begin
            if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
        end
    end
endtask

function automatic csr_data_t expected_word(input int idx);
    csr_data_t w;
    case (idx)
        1: w = {25'b0, tag_current, tag_in_done, vcap_out_done, vcap_current,
                vcap_in_done, spi_ready, serdes_locked};
        2: w = {spi_ready, model[2][30], 5'b0, model[2][24:16], model[2][15:0]};
        3: w = {spi_ready, model[2][30], 5'b0, model[2][24:16], spi_rdata};
        0, 4, 5, 6, 7, 8, 9: w = model[idx];
        default: w = '0;
    endcase
    return w;
endfunction

task automatic check_read(input int idx, input int stall);
    csr_data_t exp;
    resp_t     exp_resp;
    exp      = expected_word(idx);
    exp_resp = (idx < `CSR_WORD_N) ? OKAY : SLVERR;
    axi_read(idx, stall);
    if (last_rdata !== exp || last_rresp !== exp_resp) begin
        $display("** Error at %0t: read of word %0d gave %h/%0d, expected %h/%0d",
                 $time, idx, last_rdata, last_rresp, exp, exp_resp);
        errors++;
    end
endtask

task automatic check_outputs();
    logic [6:0] en_exp;
    en_exp = {model[0][24], model[0][16], model[0][9], model[0][8],
              model[0][2], model[0][1], model[0][0]};
    compare("enable outputs", 32'({tag_enable, vcap_enable, trigger_enable,
            exposure_enable, subsample, serdes_enable, soft_reset}), 32'(en_exp));
    compare("frame_period", frame_period, model[4]);
    compare("exposure_0", exposure_0, model[5]);
    compare("exposure_1", exposure_1, model[6]);
    compare("exposure_2", exposure_2, model[7]);
    compare("strobe_period", strobe_period, model[8]);
    compare("strobe_width", strobe_width, model[9]);
    compare("spi_addr", 32'(spi_addr), 32'(model[2][24:16]));
    compare("spi_op", 32'(spi_op), 32'(model[2][30]));
    compare("spi_wdata", 32'(spi_wdata), 32'(model[2][15:0]));
endtask

task automatic write_and_check(input int idx, input csr_data_t data, input csr_strb_t strb,
                               input int stall);
    logic want;
    want = (idx == 2) && strb[3];
    axi_write(idx, data, strb, stall);
    model_write(idx, data, strb);
    if (start_first !== want || start_hits != (want ? 1 : 0)) begin
        $display("** Error at %0t: spi_start after write to word %0d strb %b: %0d pulses",
                 $time, idx, strb, start_hits);
        errors++;
    end
endtask

task automatic set_event(input int src, input logic val);
    case (src)
        0: serdes_locked = val;
        1: spi_ready     = val;
        2: vcap_in_done  = val;
        3: vcap_out_done = val;
        default: tag_in_done = val;
    endcase
endtask

////////////////////////////////////////////////////////////////////////////
initial begin
    int        n;
    int        k;
    int        idx;
    int        src;
    int        hits;
    int        hit_at;
    csr_data_t data;
    csr_data_t rnd;
    logic      en;
    errors = 0;
    timeouts = 0;
    seed = 32'h4d8daf57;
    aresetn = 1'b0;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    spi_rdata = '0;
    {spi_ready, serdes_locked, vcap_in_done, vcap_out_done} = 4'b0;
    {tag_in_done, vcap_current, tag_current} = 3'b0;
    for (n = 0; n < `CSR_WORD_N; n++) model[n] = '0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    if (s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready || s_axi_rvalid
        || spi_start || irq_request || soft_reset || serdes_enable || subsample
        || exposure_enable || trigger_enable || vcap_enable || tag_enable) begin
        $display("** Error at %0t: outputs not low after reset", $time);
        errors++;
    end

    // random traffic on the writable words
    for (n = 0; n < 80; n++) begin
        idx  = wr_list[{$random(seed)} % 8];
        data = $random(seed);
        rnd  = $random(seed);
        spi_rdata = rnd[31:16];
        spi_ready = rnd[8];
        write_and_check(idx, data, rnd[3:0], {$random(seed)} % 4);
        check_read(idx, {$random(seed)} % 4);
        check_outputs();
    end

    // spi start strobe
    write_and_check(2, 32'hc1a5_5a5a, 4'b1000, 0);
    write_and_check(2, 32'h0123_4567, 4'b0111, 1);
    spi_rdata = 16'hbeef;
    check_read(3, 2);
    check_read(2, 0);
    check_outputs();

    // unmapped and read-only words
    for (idx = `CSR_WORD_N; idx < 64; idx++) check_read(idx, 0);
    for (n = 0; n < 20; n++) begin
        k   = {$random(seed)} % 56;
        idx = (k < 2) ? 1 + 2 * k : k + 8;
        write_and_check(idx, $random(seed), 4'hf, {$random(seed)} % 3);
    end
    for (k = 0; k < 8; k++) check_read(wr_list[k], 0);
    check_outputs();

    // status word
    for (n = 0; n < 12; n++) begin
        rnd = $random(seed);
        {tag_current, tag_in_done, vcap_out_done, vcap_current} = rnd[6:3];
        {vcap_in_done, spi_ready, serdes_locked} = rnd[2:0];
        repeat (3) @(negedge aclk);
        check_read(1, {$random(seed)} % 3);
    end
    {spi_ready, serdes_locked, vcap_in_done, vcap_out_done} = 4'b0;
    {tag_in_done, vcap_current, tag_current} = 3'b0;
    repeat (4) @(negedge aclk);

    // rising edge interrupts
    for (n = 0; n < 30; n++) begin
        write_and_check(0, $random(seed), 4'hf, 0);
        src = {$random(seed)} % 5;
        en  = model[0][irq_bit[src]];
        set_event(src, 1'b1);
        hits   = 0;
        hit_at = 0;
        for (k = 1; k <= 8; k++) begin
            @(negedge aclk);
            if (irq_request) begin
                hits++;
                hit_at = k;
            end
        end
        // lock goes through the two-stage synchronizer
        if ((en && (hits != 1 || hit_at != ((src == 0) ? 3 : 1))) || (!en && hits != 0)) begin
            $display("** Error at %0t: irq source %0d enable %0b gave %0d pulses, last at %0d",
                     $time, src, en, hits, hit_at);
            errors++;
        end
        set_event(src, 1'b0);
        repeat (4) @(negedge aclk);
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

/* src/cam_csr_top.sv */
`timescale 1ns/10ps
`include "cam_csr_cfg.svh"

module cam_csr_top
    import cam_csr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   aresetn,

    input  csr_addr_t              s_axi_awaddr,
    input  logic                   s_axi_awvalid,
    output logic                   s_axi_awready,
    input  csr_data_t              s_axi_wdata,
    input  csr_strb_t              s_axi_wstrb,
    input  logic                   s_axi_wvalid,
    output logic                   s_axi_wready,
    output resp_t                  s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,
    input  csr_addr_t              s_axi_araddr,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,
    output csr_data_t              s_axi_rdata,
    output resp_t                  s_axi_rresp,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,

    output logic                   soft_reset,
    output logic                   serdes_enable,
    output logic                   subsample,
    output logic                   exposure_enable,
    output logic                   trigger_enable,
    output logic                   vcap_enable,
    output logic                   tag_enable,

    output logic                   spi_start,
    output logic [`SPI_ADDR_W-1:0] spi_addr,
    output spi_op_e                spi_op,
    output logic [`SPI_DATA_W-1:0] spi_wdata,
    input  logic [`SPI_DATA_W-1:0] spi_rdata,
    input  logic                   spi_ready,

    output csr_data_t              frame_period,
    output csr_data_t              exposure_0,
    output csr_data_t              exposure_1,
    output csr_data_t              exposure_2,
    output csr_data_t              strobe_period,
    output csr_data_t              strobe_width,

    input  logic                   serdes_locked,
    input  logic                   vcap_in_done,
    input  logic                   vcap_out_done,
    input  logic                   tag_in_done,
    input  logic                   vcap_current,
    input  logic                   tag_current,
    output logic                   irq_request
);

logic                  wr_en;
csr_index_e            wr_index;
csr_data_t             wr_data;
csr_strb_t             wr_strb;
csr_index_e            rd_index;
csr_data_t             cfg_rdata;
logic                  cfg_hit;
csr_data_t             status_word;
logic [`IRQ_SRC_N-1:0] irq_enable;

cam_axil_port u_port (.*);

cam_config_regs u_regs (.*);

cam_event_unit u_event (.*);

endmodule

/* src/cam_event_unit.sv */
`timescale 1ns/10ps
`include "cam_csr_cfg.svh"

module cam_event_unit
    import cam_csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  serdes_locked,
    input  logic                  spi_ready,
    input  logic                  vcap_in_done,
    input  logic                  vcap_out_done,
    input  logic                  tag_in_done,
    input  logic                  vcap_current,
    input  logic                  tag_current,

    input  logic [`IRQ_SRC_N-1:0] irq_enable,
    output csr_data_t             status_word,
    output logic                  irq_request
);

// serdes lock comes from the sensor clock domain
logic [1:0] lock_sync;
logic       lock_s;

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        lock_sync <= 2'b00;
    end else begin
        lock_sync <= {lock_sync[0], serdes_locked};
    end
end

assign lock_s = lock_sync[1];

////////////////////////////////////////////////////////////////////////////
// rising edge interrupt
logic [`IRQ_SRC_N-1:0] src_now;
logic [`IRQ_SRC_N-1:0] src_prev;

assign src_now = {tag_in_done, vcap_out_done, vcap_in_done, spi_ready, lock_s};

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        src_prev    <= '0;
        irq_request <= 1'b0;
    end else begin
        src_prev    <= src_now;
        irq_request <= |(src_now & ~src_prev & irq_enable);
    end
end

always_comb begin
    status_word    = '0;
    status_word[0] = lock_s;
    status_word[1] = spi_ready;
    status_word[2] = vcap_in_done;
    status_word[3] = vcap_current;
    status_word[4] = vcap_out_done;
    status_word[5] = tag_in_done;
    status_word[6] = tag_current;
end

endmodule

/* src/cam_config_regs.sv */
`timescale 1ns/10ps
`include "cam_csr_cfg.svh"

module cam_config_regs
    import cam_csr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   wr_en,
    input  csr_index_e             wr_index,
    input  csr_data_t              wr_data,
    input  csr_strb_t              wr_strb,
    input  csr_index_e             rd_index,
    output csr_data_t              cfg_rdata,
    output logic                   cfg_hit,

    output logic                   soft_reset,
    output logic                   serdes_enable,
    output logic                   subsample,
    output logic                   exposure_enable,
    output logic                   trigger_enable,
    output logic                   vcap_enable,
    output logic                   tag_enable,
    output logic [`IRQ_SRC_N-1:0]  irq_enable,

    output logic                   spi_start,
    output logic [`SPI_ADDR_W-1:0] spi_addr,
    output spi_op_e                spi_op,
    output logic [`SPI_DATA_W-1:0] spi_wdata,
    input  logic [`SPI_DATA_W-1:0] spi_rdata,
    input  logic                   spi_ready,

    output csr_data_t              frame_period,
    output csr_data_t              exposure_0,
    output csr_data_t              exposure_1,
    output csr_data_t              exposure_2,
    output csr_data_t              strobe_period,
    output csr_data_t              strobe_width
);

csr_data_t ctrl_q;
csr_data_t spi_cmd_q;

// byte-lane update of one word
function automatic csr_data_t merge_bytes(csr_data_t cur, csr_data_t data, csr_strb_t strb);
    csr_data_t res;
    res = cur;
    for (int b = 0; b < `CSR_STRB_W; b++) begin
        if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
endfunction

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        ctrl_q        <= '0;
        spi_cmd_q     <= '0;
        frame_period  <= '0;
        exposure_0    <= '0;
        exposure_1    <= '0;
        exposure_2    <= '0;
        strobe_period <= '0;
        strobe_width  <= '0;
    end else if (wr_en) begin
        case (wr_index)
            CTRL:          ctrl_q <= merge_bytes(ctrl_q, wr_data, wr_strb);
            SPI_CMD:       spi_cmd_q <= merge_bytes(spi_cmd_q, wr_data, wr_strb);
            FRAME_PERIOD:  frame_period <= merge_bytes(frame_period, wr_data, wr_strb);
            EXPOSURE_0:    exposure_0 <= merge_bytes(exposure_0, wr_data, wr_strb);
            EXPOSURE_1:    exposure_1 <= merge_bytes(exposure_1, wr_data, wr_strb);
            EXPOSURE_2:    exposure_2 <= merge_bytes(exposure_2, wr_data, wr_strb);
            STROBE_PERIOD: strobe_period <= merge_bytes(strobe_period, wr_data, wr_strb);
            STROBE_WIDTH:  strobe_width <= merge_bytes(strobe_width, wr_data, wr_strb);
            default: ;
        endcase
    end
end

////////////////////////////////////////////////////////////////////////////
// control fields
assign soft_reset      = ctrl_q[0];
assign serdes_enable   = ctrl_q[1];
assign subsample       = ctrl_q[2];
assign exposure_enable = ctrl_q[8];
assign trigger_enable  = ctrl_q[9];
assign vcap_enable     = ctrl_q[16];
assign tag_enable      = ctrl_q[24];

// bit 0 is the serdes lock source
assign irq_enable = {ctrl_q[28], ctrl_q[22], ctrl_q[20], ctrl_q[7], ctrl_q[4]};

assign spi_wdata = spi_cmd_q[`SPI_DATA_LSB +: `SPI_DATA_W];
assign spi_addr  = spi_cmd_q[`SPI_ADDR_LSB +: `SPI_ADDR_W];
assign spi_op    = spi_op_e'(spi_cmd_q[`SPI_OP_BIT]);

// the top byte holds the opcode, so writing it launches a transfer
always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        spi_start <= 1'b0;
    end else begin
        spi_start <= wr_en && (wr_index == SPI_CMD) && wr_strb[`SPI_START_STRB];
    end
end

////////////////////////////////////////////////////////////////////////////
// read data
assign cfg_hit = (rd_index < `CSR_WORD_N);

always_comb begin
    cfg_rdata = '0;
    case (rd_index)
        CTRL: cfg_rdata = ctrl_q;
        SPI_CMD, SPI_RESULT: begin
            cfg_rdata[`SPI_READY_BIT] = spi_ready;
            cfg_rdata[`SPI_OP_BIT] = spi_op;
            cfg_rdata[`SPI_ADDR_LSB +: `SPI_ADDR_W] = spi_addr;
            cfg_rdata[`SPI_DATA_LSB +: `SPI_DATA_W] =
                (rd_index == SPI_CMD) ? spi_wdata : spi_rdata;
        end
        FRAME_PERIOD:  cfg_rdata = frame_period;
        EXPOSURE_0:    cfg_rdata = exposure_0;
        EXPOSURE_1:    cfg_rdata = exposure_1;
        EXPOSURE_2:    cfg_rdata = exposure_2;
        STROBE_PERIOD: cfg_rdata = strobe_period;
        STROBE_WIDTH:  cfg_rdata = strobe_width;
        default: ;
    endcase
end

spi_start_single: assert property (@(posedge aclk) disable iff (!aresetn)
    spi_start |=> !spi_start);

endmodule

/* src/cam_axil_port.sv */
`timescale 1ns/10ps
`include "cam_csr_cfg.svh"

module cam_axil_port
    import cam_csr_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    input  csr_addr_t   s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,

    input  csr_data_t   s_axi_wdata,
    input  csr_strb_t   s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,

    output resp_t       s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,

    input  csr_addr_t   s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,

    output csr_data_t   s_axi_rdata,
    output resp_t       s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,

    output logic        wr_en,
    output csr_index_e  wr_index,
    output csr_data_t   wr_data,
    output csr_strb_t   wr_strb,
    output csr_index_e  rd_index,

    input  csr_data_t   cfg_rdata,
    input  logic        cfg_hit,
    input  csr_data_t   status_word
);

////////////////////////////////////////////////////////////////////////////
// write channel
axil_state_e wr_state;

// address and data must arrive together
assign wr_en         = (wr_state == IDLE) && s_axi_awvalid && s_axi_wvalid;
assign s_axi_awready = wr_en;
assign s_axi_wready  = wr_en;
assign wr_index      = csr_index_e'(s_axi_awaddr[`CSR_ADDR_W-1:2]);
assign wr_data       = s_axi_wdata;
assign wr_strb       = s_axi_wstrb;

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        wr_state <= IDLE;
    end else if (wr_state == IDLE) begin
        if (wr_en) wr_state <= RESP;
    end else if (s_axi_bready) begin
        wr_state <= IDLE;
    end
end

assign s_axi_bvalid = (wr_state == RESP);
// unmapped and read-only words are silently ignored
assign s_axi_bresp  = OKAY;

////////////////////////////////////////////////////////////////////////////
// read channel
axil_state_e rd_state;

assign s_axi_arready = (rd_state == IDLE) && s_axi_arvalid;
assign rd_index      = csr_index_e'(s_axi_araddr[`CSR_ADDR_W-1:2]);

always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
        rd_state <= IDLE;
    end else if (rd_state == IDLE) begin
        if (s_axi_arready) rd_state <= RESP;
    end else if (s_axi_rready) begin
        rd_state <= IDLE;
    end
end

// capture once, held while rvalid waits
always_ff @(posedge aclk) begin
    if (s_axi_arready) begin
        if (rd_index == STATUS) begin
            s_axi_rdata <= status_word;
            s_axi_rresp <= OKAY;
        end else if (cfg_hit) begin
            s_axi_rdata <= cfg_rdata;
            s_axi_rresp <= OKAY;
        end else begin
            s_axi_rdata <= '0;
            s_axi_rresp <= SLVERR;
        end
    end
end

assign s_axi_rvalid = (rd_state == RESP);

bvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);
rvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

/* src/cam_csr_pkg.sv */
`include "cam_csr_cfg.svh"

package cam_csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;
    typedef logic [`CSR_STRB_W-1:0] csr_strb_t;

    // word index, byte address bits 7:2
    typedef enum logic [`CSR_ADDR_W-3:0] {
        CTRL          = 6'd0,
        STATUS        = 6'd1,
        SPI_CMD       = 6'd2,
        SPI_RESULT    = 6'd3,
        FRAME_PERIOD  = 6'd4,
        EXPOSURE_0    = 6'd5,
        EXPOSURE_1    = 6'd6,
        EXPOSURE_2    = 6'd7,
        STROBE_PERIOD = 6'd8,
        STROBE_WIDTH  = 6'd9
    } csr_index_e;

    typedef enum logic {
        SPI_WRITE = 1'b0,
        SPI_READ  = 1'b1
    } spi_op_e;

    typedef enum logic {
        IDLE,
        RESP
    } axil_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

endpackage

/* src/cam_csr_cfg.svh */
`ifndef CAM_CSR_CFG_SVH
`define CAM_CSR_CFG_SVH

// AXI4-Lite register bus
`define CSR_ADDR_W 8
`define CSR_DATA_W 32
`define CSR_STRB_W 4

// implemented words, CTRL up to STROBE_WIDTH
`define CSR_WORD_N 10

// SPI command word layout
`define SPI_ADDR_W 9
`define SPI_DATA_W 16
`define SPI_DATA_LSB 0
`define SPI_ADDR_LSB 16
`define SPI_OP_BIT 30
`define SPI_READY_BIT 31
// byte strobe that fires the SPI start pulse
`define SPI_START_STRB 3

// interrupt sources
`define IRQ_SRC_N 5

`endif
